// ==== list.f ====
+incdir+include
verilog/fftPkg.sv
verilog/syncFifo.sv
verilog/butterflyUnit.sv
verilog/fftSequencer.sv
verilog/memPort.sv
verilog/fftEngine.sv
tests/memoryModel.sv
tests/fftEngineTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fftEngineTb
FLAGS ?= --binary --assert --timing -Wno-fatal
OBJ_DIR ?= obj_dir

SOURCES := $(filter-out +%,$(shell cat list.f)) include/fft_params.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) list.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/fftEngineTb.sv ====
`timescale 1ns/10ps
`include "fft_params.svh"

module fftEngineTb;

	import fftPkg::*;

	// 40 cycles per memory access over all tests plus a margin
	localparam int ACCESSES = 385;
	localparam int LIMIT_CYCLES = ACCESSES * 40 + 2000;

	logic CLK;
	logic RESET;
	logic cmdAct;
	logic cmdNext;
	fftCmdT cmd;
	logic memAct;
	logic memNext;
	memReqT memReq;
	logic memDrdy;
	memRspT memRsp;

	int seed;
	int errors;
	int reqErrors;
	int failedTests;
	int readCount;
	int writeCount;
	int curData;
	int curTw;
	int curN;
	logic [31:0] refMem [0:4095];
	logic [31:0] savedIn [0:15];

	fftEngine fftEngine_inst (.CLK(CLK), .RESET(RESET), .cmdAct(cmdAct), .cmdNext(cmdNext),
		.cmd(cmd), .memAct(memAct), .memNext(memNext), .memReq(memReq),
		.memDrdy(memDrdy), .memRsp(memRsp));

	memoryModel memInst (.CLK(CLK), .RESET(RESET), .memAct(memAct), .memNext(memNext),
		.memReq(memReq), .memDrdy(memDrdy), .memRsp(memRsp));

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		#(LIMIT_CYCLES * 10);
		$display("timeout, the engine did not finish its commands in time");
		$display("Test FAILED");
		$finish;
	end

	// request must hold while memory stalls
	assert property (@(posedge CLK) disable iff (!RESET)
		(memAct && !memNext) |=> (memAct && $stable(memReq)))
	else begin
		$display("[FAIL] memReq changed under stall, now %h", memReq);
		errors++;
	end

	// counting, tag and range checks on every transfer
	always @(posedge CLK) begin
		memTagT expTag;
		expTag = WRITE;
		if (RESET && memAct && memNext) begin
			if (memReq.write) begin
				writeCount++;
				assert (memReq.tag == WRITE) else begin
					$display("[FAIL] memReq.tag got %h exp %h", memReq.tag, WRITE);
					errors++;
					reqErrors++;
				end
			end else begin
				// each butterfly reads the twiddle, then Y, then X
				case (readCount % 3)
					0: expTag = TWIDDLE;
					1: expTag = YOPER;
					default: expTag = XOPER;
				endcase
				readCount++;
				assert (memReq.tag == expTag) else begin
					$display("[FAIL] memReq.tag got %h exp %h", memReq.tag, expTag);
					errors++;
					reqErrors++;
				end
			end
			if (expTag == TWIDDLE) begin
				assert (int'(memReq.addr) >= curTw && int'(memReq.addr) < curTw + curN / 2)
				else begin
					$display("[FAIL] memReq.addr got %h outside twiddle table at %h",
						memReq.addr, curTw);
					errors++;
					reqErrors++;
				end
			end else begin
				assert (int'(memReq.addr) >= curData && int'(memReq.addr) < curData + curN)
				else begin
					$display("[FAIL] memReq.addr got %h outside data table at %h",
						memReq.addr, curData);
					errors++;
					reqErrors++;
				end
			end
		end
	end

	// fixed-point butterfly with a floor shift of W*Y and a 16-bit wrap
	task automatic bfly(inout logic [31:0] x, inout logic [31:0] y, input logic [31:0] w);
		longint xr;
		longint xi;
		longint yr;
		longint yi;
		longint wr;
		longint wi;
		longint pr;
		longint pi;
		logic [15:0] sr;
		logic [15:0] si;
		logic [15:0] dr;
		logic [15:0] di;
		xr = longint'($signed(x[15:0]));
		xi = longint'($signed(x[31:16]));
		yr = longint'($signed(y[15:0]));
		yi = longint'($signed(y[31:16]));
		wr = longint'($signed(w[15:0]));
		wi = longint'($signed(w[31:16]));
		pr = (yr * wr - yi * wi) >>> `TW_FRAC;
		pi = (yr * wi + yi * wr) >>> `TW_FRAC;
		sr = 16'(xr + pr);
		si = 16'(xi + pi);
		dr = 16'(xr - pr);
		di = 16'(xi - pi);
		x = {si, sr};
		y = {di, dr};
	endtask

	task automatic refFft(input int db, input int tw, input int par);
		int n;
		int half;
		int e;
		int o;
		n = 1 << par;
		for (int s = 0; s < par; s++) begin
			half = 1 << s;
			for (int b = 0; b < n / (2 * half); b++) begin
				for (int j = 0; j < half; j++) begin
					e = 2 * half * b + j;
					o = e + half;
					bfly(refMem[db + e], refMem[db + o], refMem[tw + j * n / (2 * half)]);
				end
			end
		end
	endtask

	task automatic loadTwiddles(input int tw, input int n);
		real ang;
		real c;
		real s;
		int re;
		int im;
		for (int k = 0; k < n / 2; k++) begin
			ang = 2.0 * 3.14159265358979 * k / n;
			c = $cos(ang) * 16384.0;
			s = -$sin(ang) * 16384.0;
			re = (c >= 0.0) ? $rtoi(c + 0.5) : -$rtoi(-c + 0.5);
			im = (s >= 0.0) ? $rtoi(s + 0.5) : -$rtoi(-s + 0.5);
			memInst.mem[tw + k] = {im[15:0], re[15:0]};
			refMem[tw + k] = {im[15:0], re[15:0]};
		end
	endtask

	task automatic loadData(input int db, input int n, input bit reuse);
		logic [31:0] word;
		for (int i = 0; i < n; i++) begin
			word = reuse ? savedIn[i] : $random(seed);
			savedIn[i] = word;
			memInst.mem[db + i] = word;
			refMem[db + i] = word;
		end
	endtask

	task automatic checkData(input int db, input int n);
		for (int i = 0; i < n; i++) begin
			assert (memInst.mem[db + i] == refMem[db + i]) else begin
				$display("[FAIL] mem[%h] got %h exp %h", db + i, memInst.mem[db + i],
					refMem[db + i]);
				errors++;
			end
		end
	endtask

	task automatic runFft(input int db, input int tw, input int par, input int maxCycles);
		int cycles;
		int n;
		n = 1 << par;
		curData = db;
		curTw = tw;
		curN = n;
		readCount = 0;
		writeCount = 0;
		while (!cmdNext) @(negedge CLK);
		cmd = '{dataBase: offsetT'(db), twiddleBase: offsetT'(tw), par: parT'(par)};
		cmdAct = 1'b1;
		@(negedge CLK);
		cmdAct = 1'b0;
		cycles = 0;
		while (!cmdNext && cycles < maxCycles) begin
			@(negedge CLK);
			cycles++;
		end
		assert (cmdNext) else begin
			$display("command with par %0d did not complete in %0d cycles", par, maxCycles);
			errors++;
		end
		assert (readCount == 3 * (n / 2) * par) else begin
			$display("[FAIL] read count got %h exp %h", readCount, 3 * (n / 2) * par);
			errors++;
			reqErrors++;
		end
		assert (writeCount == n * par) else begin
			$display("[FAIL] write count got %h exp %h", writeCount, n * par);
			errors++;
			reqErrors++;
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errCount);
		if (errCount == 0) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: fail, %0d errors", num, name, errCount);
			failedTests++;
		end
	endtask

	initial begin
		int errBefore;
		seed = 32'hb68a_3b5a;
		errors = 0;
		reqErrors = 0;
		failedTests = 0;
		readCount = 0;
		writeCount = 0;
		curData = 0;
		curTw = 0;
		curN = 1;
		RESET = 1'b0;
		cmdAct = 1'b0;
		cmd = '0;
		for (int i = 0; i < 4096; i++) begin
			memInst.mem[i] = 32'(i * 32'h9e37 + 32'h5a5a);
			refMem[i] = 32'(i * 32'h9e37 + 32'h5a5a);
		end
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;

		// reset values, then an empty transform
		errBefore = errors;
		assert (cmdNext && !memAct) else begin
			$display("[FAIL] cmdNext got %h memAct got %h exp 1 and 0", cmdNext, memAct);
			errors++;
		end
		runFft(32'h100, 32'h80, 0, 4);
		reportTest(1, "reset and par 0", errors - errBefore);

		errBefore = errors;
		memInst.maxLat = 1;
		loadTwiddles(32'h80, 2);
		loadData(32'h100, 2, 1'b0);
		refFft(32'h100, 32'h80, 1);
		runFft(32'h100, 32'h80, 1, 200);
		checkData(32'h100, 2);
		reportTest(2, "single butterfly", errors - errBefore);

		errBefore = errors;
		memInst.maxLat = 8;
		loadTwiddles(32'h40, 16);
		loadData(32'h200, 16, 1'b0);
		refFft(32'h200, 32'h40, 4);
		runFft(32'h200, 32'h40, 4, 6000);
		checkData(32'h200, 16);
		reportTest(3, "16 points, random latency", errors - errBefore);

		// same input as test 3, so the same expected words
		errBefore = errors;
		memInst.stallPct = 40;
		memInst.maxLat = 6;
		loadData(32'h300, 16, 1'b1);
		refFft(32'h300, 32'h40, 4);
		runFft(32'h300, 32'h40, 4, 6000);
		checkData(32'h300, 16);
		reportTest(4, "16 points, memory stalls", errors - errBefore);

		errBefore = errors;
		loadTwiddles(32'h20, 8);
		loadData(32'h400, 8, 1'b0);
		refFft(32'h400, 32'h20, 3);
		runFft(32'h400, 32'h20, 3, 4000);
		checkData(32'h400, 8);
		reportTest(6, "second command, 8 points", errors - errBefore);

		// counts, tags and addresses of every run
		reportTest(5, "request counts and addresses", reqErrors);

		$display("6 tests, %0d failed, %0d failed checks", failedTests, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== tests/memoryModel.sv ====
`timescale 1ns/10ps

module memoryModel (
	input logic CLK,
	input logic RESET,
	input logic memAct,
	output logic memNext,
	input fftPkg::memReqT memReq,
	output logic memDrdy,
	output fftPkg::memRspT memRsp
);

	import fftPkg::*;

	// the low 12 address bits select a word
	logic [31:0] mem [0:4095];
	// percent of cycles with memNext low, and the largest read latency
	int stallPct;
	int maxLat;
	int seed;
	int cycle;
	int lastDue;
	int dueQ [$];
	memRspT rspQ [$];

	initial begin
		seed = 32'hb68a_3b5a;
		stallPct = 0;
		maxLat = 1;
		cycle = 0;
		lastDue = 0;
		memNext = 1'b0;
		memDrdy = 1'b0;
		memRsp = '0;
	end

	// requests apply in order, so a later read sees an earlier write
	always @(posedge CLK) begin
		int lat;
		int due;
		cycle = cycle + 1;
		if (RESET && memAct && memNext) begin
			if (memReq.write) begin
				mem[memReq.addr[11:0]] = memReq.data;
			end else begin
				lat = 1 + int'($unsigned($random(seed)) % maxLat);
				due = cycle + lat;
				if (due <= lastDue) begin
					due = lastDue + 1;
				end
				lastDue = due;
				dueQ.push_back(due);
				rspQ.push_back(memRspT'{data: mem[memReq.addr[11:0]], tag: memReq.tag});
			end
		end
	end

	always @(negedge CLK) begin
		memNext = (int'($unsigned($random(seed)) % 100) >= stallPct);
		memDrdy = 1'b0;
		if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
			memDrdy = 1'b1;
			memRsp = rspQ.pop_front();
			void'(dueQ.pop_front());
		end
	end

endmodule

// ==== verilog/fftEngine.sv ====
`timescale 1ns/10ps
`include "fft_params.svh"

module fftEngine (
	input logic CLK,
	input logic RESET,
	input logic cmdAct,
	output logic cmdNext,
	input fftPkg::fftCmdT cmd,
	output logic memAct,
	input logic memNext,
	output fftPkg::memReqT memReq,
	input logic memDrdy,
	input fftPkg::memRspT memRsp
);

	import fftPkg::*;

	logic busy;
	logic cmdTake;
	fftCmdT cmdReg;
	logic seqDone;
	logic rdAct;
	logic rdNext;
	offsetT rdOffset;
	memTagT rdTag;
	logic pairPush;
	logic pairPop;
	logic pairEmpty;
	logic [`FIFO_AW:0] pairUsed;
	pairAddrT pairIn;
	pairAddrT pairHead;
	logic writesIdle;
	logic twPush;
	logic yPush;
	logic xPush;
	complexT rspData;
	complexT twHead;
	complexT yHead;
	complexT xHead;
	logic twEmpty;
	logic yEmpty;
	logic xEmpty;
	logic opPop;
	logic bfAct;
	resultT bfResult;
	resultT resHead;
	logic resPop;
	logic resEmpty;

	assign cmdNext = !busy;
	assign cmdTake = cmdAct && cmdNext;
	// one butterfly enters when all three operands are present
	assign opPop = !twEmpty && !yEmpty && !xEmpty;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			busy <= 1'b0;
		end else begin
			busy <= (busy || cmdTake) && !seqDone;
		end
	end

	always_ff @(posedge CLK) begin
		if (cmdTake) begin
			cmdReg.dataBase <= cmd.dataBase;
			cmdReg.twiddleBase <= cmd.twiddleBase;
			// codes above the limit saturate
			cmdReg.par <= (cmd.par > `MAX_PAR) ? parT'(`MAX_PAR) : cmd.par;
		end
	end

	fftSequencer sequencerInst (.CLK(CLK), .RESET(RESET), .start(cmdTake), .cmd(cmdReg),
		.rdAct(rdAct), .rdNext(rdNext), .rdOffset(rdOffset), .rdTag(rdTag),
		.pairPush(pairPush), .pairAddr(pairIn), .pairUsed(pairUsed),
		.writesIdle(writesIdle), .done(seqDone));

	memPort memPortInst (.CLK(CLK), .RESET(RESET), .dataBase(cmdReg.dataBase),
		.rdAct(rdAct), .rdOffset(rdOffset), .rdTag(rdTag), .rdNext(rdNext),
		.pairPop(pairPop), .pairAddr(pairHead), .pairEmpty(pairEmpty),
		.resPop(resPop), .result(resHead), .resEmpty(resEmpty), .writesIdle(writesIdle),
		.memAct(memAct), .memNext(memNext), .memReq(memReq), .memDrdy(memDrdy),
		.memRsp(memRsp), .twPush(twPush), .yPush(yPush), .xPush(xPush), .rspData(rspData));

	butterflyUnit butterflyInst (.CLK(CLK), .RESET(RESET), .inAct(opPop), .twiddle(twHead),
		.yOper(yHead), .xOper(xHead), .outAct(bfAct), .result(bfResult));

	syncFifo #(.WIDTH($bits(complexT)), .DEPTH(`FIFO_DEPTH)) twFifo (.CLK(CLK), .RESET(RESET),
		.push(twPush), .pushData(rspData), .pop(opPop), .popData(twHead), .empty(twEmpty),
		.used());

	syncFifo #(.WIDTH($bits(complexT)), .DEPTH(`FIFO_DEPTH)) yFifo (.CLK(CLK), .RESET(RESET),
		.push(yPush), .pushData(rspData), .pop(opPop), .popData(yHead), .empty(yEmpty),
		.used());

	syncFifo #(.WIDTH($bits(complexT)), .DEPTH(`FIFO_DEPTH)) xFifo (.CLK(CLK), .RESET(RESET),
		.push(xPush), .pushData(rspData), .pop(opPop), .popData(xHead), .empty(xEmpty),
		.used());

	syncFifo #(.WIDTH($bits(pairAddrT)), .DEPTH(`FIFO_DEPTH)) pairFifo (.CLK(CLK),
		.RESET(RESET), .push(pairPush), .pushData(pairIn), .pop(pairPop),
		.popData(pairHead), .empty(pairEmpty), .used(pairUsed));

	syncFifo #(.WIDTH($bits(resultT)), .DEPTH(`FIFO_DEPTH)) resFifo (.CLK(CLK), .RESET(RESET),
		.push(bfAct), .pushData(bfResult), .pop(resPop), .popData(resHead), .empty(resEmpty),
		.used());

endmodule

// ==== verilog/memPort.sv ====
`timescale 1ns/10ps

module memPort (
	input logic CLK,
	input logic RESET,
	input fftPkg::offsetT dataBase,
	input logic rdAct,
	input fftPkg::offsetT rdOffset,
	input fftPkg::memTagT rdTag,
	output logic rdNext,
	output logic pairPop,
	input fftPkg::pairAddrT pairAddr,
	input logic pairEmpty,
	output logic resPop,
	input fftPkg::resultT result,
	input logic resEmpty,
	output logic writesIdle,
	output logic memAct,
	input logic memNext,
	output fftPkg::memReqT memReq,
	input logic memDrdy,
	input fftPkg::memRspT memRsp,
	output logic twPush,
	output logic yPush,
	output logic xPush,
	output fftPkg::complexT rspData
);

	import fftPkg::*;

	wrStateT wrState;
	pairAddrT wrPair;
	resultT wrResult;
	memReqT nextReq;
	logic regFree;
	logic wrStart;
	logic loadEven;
	logic loadOdd;
	logic loadRead;

	always_comb begin
		regFree = !memAct || memNext;
		wrStart = (wrState == WAIT) && !pairEmpty && !resEmpty;
		loadEven = (wrState == WREVEN) && regFree;
		loadOdd = (wrState == WRODD) && regFree;
		// a pending write pair wins over reads
		rdNext = (wrState == WAIT) && !wrStart && regFree;
		loadRead = rdAct && rdNext;
		nextReq = '{write: 1'b0, addr: rdOffset, data: '0, tag: rdTag};
		if (loadEven) begin
			nextReq = '{write: 1'b1, addr: dataBase + offsetT'(wrPair.even),
				data: wrResult.sum, tag: WRITE};
		end else if (loadOdd) begin
			nextReq = '{write: 1'b1, addr: dataBase + offsetT'(wrPair.odd),
				data: wrResult.diff, tag: WRITE};
		end
	end

	assign pairPop = wrStart;
	assign resPop = wrStart;
	assign writesIdle = (wrState == WAIT) && !(memAct && memReq.write);

	// responses sorted into the operand FIFOs
	assign twPush = memDrdy && (memRsp.tag == TWIDDLE);
	assign yPush = memDrdy && (memRsp.tag == YOPER);
	assign xPush = memDrdy && (memRsp.tag == XOPER);
	assign rspData = memRsp.data;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			wrState <= WAIT;
			memAct <= 1'b0;
		end else begin
			memAct <= (memAct && !memNext) || loadEven || loadOdd || loadRead;
			case (wrState)
				WAIT: if (wrStart) wrState <= WREVEN;
				WREVEN: if (regFree) wrState <= WRODD;
				WRODD: if (regFree) wrState <= WAIT;
				default: wrState <= WAIT;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (wrStart) begin
			wrPair <= pairAddr;
			wrResult <= result;
		end
		// held while memory stalls
		if (loadEven || loadOdd || loadRead) begin
			memReq <= nextReq;
		end
	end

endmodule

// ==== verilog/fftSequencer.sv ====
`timescale 1ns/10ps
`include "fft_params.svh"

module fftSequencer (
	input logic CLK,
	input logic RESET,
	input logic start,
	input fftPkg::fftCmdT cmd,
	output logic rdAct,
	input logic rdNext,
	output fftPkg::offsetT rdOffset,
	output fftPkg::memTagT rdTag,
	output logic pairPush,
	output fftPkg::pairAddrT pairAddr,
	input logic [`FIFO_AW:0] pairUsed,
	input logic writesIdle,
	output logic done
);

	import fftPkg::*;

	seqStateT state;
	parT stage;
	indexT group;
	indexT inGroup;
	indexT twIdx;
	// twiddle stride, equal to the group count of the stage
	indexT twStep;
	indexT half;
	indexT evenIdx;
	indexT oddIdx;
	logic lastInGroup;
	logic lastGroup;
	logic lastStage;
	logic pairFull;

	always_comb begin
		half = indexT'(1) << stage;
		evenIdx = (group << (stage + 4'd1)) | inGroup;
		oddIdx = evenIdx | half;
		lastInGroup = (inGroup == half - 1'b1);
		lastGroup = (group == twStep - 1'b1);
		lastStage = (stage == cmd.par - 4'd1);
		pairFull = (pairUsed >= (`FIFO_DEPTH - 2));
	end

	// twiddle first, then Y, then X
	always_comb begin
		rdAct = 1'b0;
		rdTag = TWIDDLE;
		rdOffset = cmd.twiddleBase + offsetT'(twIdx);
		case (state)
			READTW: rdAct = 1'b1;
			READY: begin
				rdAct = 1'b1;
				rdTag = YOPER;
				rdOffset = cmd.dataBase + offsetT'(oddIdx);
			end
			READX: begin
				rdAct = 1'b1;
				rdTag = XOPER;
				rdOffset = cmd.dataBase + offsetT'(evenIdx);
			end
			default: rdAct = 1'b0;
		endcase
	end

	assign pairPush = (state == READTW) && rdNext;
	assign pairAddr = '{even: evenIdx, odd: oddIdx};

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			state <= IDLE;
			stage <= '0;
			group <= '0;
			inGroup <= '0;
			twIdx <= '0;
			twStep <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: if (start) state <= SETUP;
				SETUP: begin
					stage <= '0;
					group <= '0;
					inGroup <= '0;
					twIdx <= '0;
					twStep <= indexT'(1) << (cmd.par - 4'd1);
					if (cmd.par == '0) begin
						done <= 1'b1;
						state <= IDLE;
					end else begin
						state <= READTW;
					end
				end
				READTW: if (rdNext) state <= READY;
				READY: if (rdNext) state <= READX;
				READX: if (rdNext) state <= ADVANCE;
				ADVANCE: begin
					if (lastInGroup && lastGroup) begin
						state <= DRAIN;
					end else if (!pairFull) begin
						state <= READTW;
						if (lastInGroup) begin
							group <= group + 1'b1;
							inGroup <= '0;
							twIdx <= '0;
						end else begin
							inGroup <= inGroup + 1'b1;
							twIdx <= twIdx + twStep;
						end
					end
				end
				// stage barrier, every write of the stage has left
				DRAIN: begin
					if (pairUsed == '0 && writesIdle) begin
						group <= '0;
						inGroup <= '0;
						twIdx <= '0;
						if (lastStage) begin
							done <= 1'b1;
							state <= IDLE;
						end else begin
							stage <= stage + 1'b1;
							twStep <= twStep >> 1;
							state <= READTW;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/butterflyUnit.sv ====
`timescale 1ns/10ps
`include "fft_params.svh"

module butterflyUnit (
	input logic CLK,
	input logic RESET,
	input logic inAct,
	input fftPkg::complexT twiddle,
	input fftPkg::complexT yOper,
	input fftPkg::complexT xOper,
	output logic outAct,
	output fftPkg::resultT result
);

	import fftPkg::*;

	localparam int SW = `SAMPLE_W;
	localparam int PW = 2 * `SAMPLE_W;

	sampleT twRe;
	sampleT twIm;
	sampleT yRe;
	sampleT yIm;
	logic signed [PW-1:0] prodRR;
	logic signed [PW-1:0] prodII;
	logic signed [PW-1:0] prodRI;
	logic signed [PW-1:0] prodIR;
	logic [PW:0] mixRe;
	logic [PW:0] mixIm;
	complexT x1;
	complexT x2;
	sampleT wyRe;
	sampleT wyIm;
	logic act1;
	logic act2;

	always_comb begin
		twRe = twiddle[SW-1:0];
		twIm = twiddle[PW-1:SW];
		yRe = yOper[SW-1:0];
		yIm = yOper[PW-1:SW];
		mixRe = {prodRR[PW-1], prodRR} - {prodII[PW-1], prodII};
		mixIm = {prodRI[PW-1], prodRI} + {prodIR[PW-1], prodIR};
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			act1 <= 1'b0;
			act2 <= 1'b0;
			outAct <= 1'b0;
		end else begin
			act1 <= inAct;
			act2 <= act1;
			outAct <= act2;
		end
	end

	always_ff @(posedge CLK) begin
		// stage 1, the four partial products
		prodRR <= yRe * twRe;
		prodII <= yIm * twIm;
		prodRI <= yRe * twIm;
		prodIR <= yIm * twRe;
		x1 <= xOper;
		// stage 2, W*Y with floor shift back to sample scale
		wyRe <= mixRe[`TW_FRAC +: SW];
		wyIm <= mixIm[`TW_FRAC +: SW];
		x2 <= x1;
		// stage 3, components wrap to 16 bits
		result.sum <= {x2[PW-1:SW] + wyIm, x2[SW-1:0] + wyRe};
		result.diff <= {x2[PW-1:SW] - wyIm, x2[SW-1:0] - wyRe};
	end

endmodule

// ==== verilog/syncFifo.sv ====
`timescale 1ns/10ps

module syncFifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input logic CLK,
	input logic RESET,
	input logic push,
	input logic [WIDTH-1:0] pushData,
	input logic pop,
	output logic [WIDTH-1:0] popData,
	output logic empty,
	output logic [$clog2(DEPTH):0] used
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;

	// head word visible before the pop
	assign popData = mem[rdPtr];
	assign empty = (used == '0);

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			wrPtr <= '0;
			rdPtr <= '0;
			used <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

endmodule

// ==== verilog/fftPkg.sv ====
`include "fft_params.svh"

package fftPkg;

	// one signed real or imaginary part
	typedef logic signed [`SAMPLE_W-1:0] sampleT;
	// imaginary part in the upper half, real part in the lower half
	typedef logic [2*`SAMPLE_W-1:0] complexT;
	typedef logic [`OFFSET_W-1:0] offsetT;
	typedef logic [`INDEX_W-1:0] indexT;
	// length code, N = 2^par
	typedef logic [3:0] parT;
	typedef logic [1:0] memTagT;

	// kind of memory word, carried as the request tag
	localparam memTagT TWIDDLE = 2'd0;
	localparam memTagT XOPER = 2'd1;
	localparam memTagT YOPER = 2'd2;
	localparam memTagT WRITE = 2'd3;

	typedef struct packed {
		offsetT dataBase;
		offsetT twiddleBase;
		parT par;
	} fftCmdT;

	typedef struct packed {
		logic write;
		offsetT addr;
		complexT data;
		memTagT tag;
	} memReqT;

	typedef struct packed {
		complexT data;
		memTagT tag;
	} memRspT;

	// indices of one butterfly, waiting for its results
	typedef struct packed {
		indexT even;
		indexT odd;
	} pairAddrT;

	typedef struct packed {
		complexT sum;
		complexT diff;
	} resultT;

	typedef enum logic [2:0] {IDLE, SETUP, READTW, READY, READX, ADVANCE, DRAIN} seqStateT;
	typedef enum logic [1:0] {WAIT, WREVEN, WRODD} wrStateT;

endpackage

// ==== include/fft_params.svh ====
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

// one real or imaginary component
`define SAMPLE_W 16

// twiddle factors are Q1.14
`define TW_FRAC 14

// memory word offset
`define OFFSET_W 24

// internal FIFOs, depth is a power of two and FIFO_AW its log2
`define FIFO_DEPTH 16
`define FIFO_AW 4

// largest length code, N = 4096 points
`define MAX_PAR 12

// sample index within one transform
`define INDEX_W 12

`endif
